//--- hw/mat_pkg.sv
//////////////////////////////////////////////////////////////////////
// match-action core shared definitions
// header beat and stage result types, table command, event pulses,
// register map and command word bit positions
//////////////////////////////////////////////////////////////////////
`default_nettype none

package mat_pkg;

	// table and datapath sizes
	localparam int TBL_DEPTH = 16;
	localparam int KEY_W = 32;
	localparam int ACT_W = 32;
	localparam int PORT_W = 4;
	localparam int REG_AW = 8;
	localparam int REG_DW = 32;

	// register offsets
	localparam logic [REG_AW-1:0] REG_CMD = 8'h00;
	localparam logic [REG_AW-1:0] REG_TCAM_DATA = 8'h10;
	localparam logic [REG_AW-1:0] REG_TCAM_KEEP = 8'h14;
	localparam logic [REG_AW-1:0] REG_ACT_DATA = 8'h18;
	localparam logic [REG_AW-1:0] REG_TCAM_RD_DATA = 8'h20;
	localparam logic [REG_AW-1:0] REG_TCAM_RD_KEEP = 8'h24;
	localparam logic [REG_AW-1:0] REG_ACT_RD_DATA = 8'h28;
	localparam logic [REG_AW-1:0] REG_CNT_IN = 8'h30;
	localparam logic [REG_AW-1:0] REG_CNT_HIT = 8'h34;
	localparam logic [REG_AW-1:0] REG_CNT_OUT = 8'h38;
	localparam logic [REG_AW-1:0] REG_CNT_DROP = 8'h3C;
	localparam logic [REG_AW-1:0] REG_CLR = 8'h40;

	// command word layout
	localparam int CMD_TCAM_ADDR_LSB = 0;
	localparam int CMD_TCAM_VALID = 13;
	localparam int CMD_TCAM_RD = 14;
	localparam int CMD_TCAM_WR = 15;
	localparam int CMD_ACT_ADDR_LSB = 16;
	localparam int CMD_ACT_RD = 30;
	localparam int CMD_ACT_WR = 31;

	// action word layout
	localparam int ACT_DROP_BIT = 31;
	localparam int ACT_PORT_LSB = 0;

	typedef struct packed {
		logic [KEY_W-1:0] ipv4_dst;
		logic [7:0]       flow_id;
	} pkt_hdr_t;

	typedef struct packed {
		pkt_hdr_t   hdr;
		logic       hit;
		logic [3:0] index;
	} match_res_t;

	typedef struct packed {
		pkt_hdr_t          hdr;
		logic              hit;
		logic              drop;
		logic [PORT_W-1:0] port;
	} act_res_t;

	typedef struct packed {
		pkt_hdr_t          hdr;
		logic [PORT_W-1:0] port;
	} out_hdr_t;

	typedef struct packed {
		logic       tcam_wr;
		logic       tcam_rd;
		logic       act_wr;
		logic       act_rd;
		logic [3:0] tcam_addr;
		logic [3:0] act_addr;
		logic       entry_valid;
	} tbl_cmd_t;

	typedef struct packed {
		logic in_beat;
		logic hit;
		logic out_beat;
		logic drop;
	} stat_ev_t;

endpackage

`default_nettype wire

//--- hw/pipe_stage.sv
//////////////////////////////////////////////////////////////////////
// valid/ready register stage
// one payload slot, full throughput, generic over the payload type
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module pipe_stage #(
	parameter type payload_t = logic
) (
	input  wire            clk,
	input  wire            rst,
	input  wire payload_t  in_data,
	input  wire            in_valid,
	output logic           in_ready,
	output payload_t       out_data,
	output logic           out_valid,
	input  wire            out_ready
);

	// accept when empty or when the held beat leaves this cycle
	assign in_ready = !out_valid || out_ready;

	// payload slot
	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			out_data <= in_data;
		end
	end

	// occupancy flag
	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	// an offered beat stays offered until this stage takes it
	assert property (@(posedge clk) disable iff (rst)
		in_valid && !in_ready |=> in_valid);

endmodule

`default_nettype wire

//--- hw/tcam_match.sv
//////////////////////////////////////////////////////////////////////
// ternary match stage
// data/keep/valid entry store with write and read back, lowest
// hitting index wins, result registered into a pipeline stage
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tcam_match import mat_pkg::*; #(
	parameter int DEPTH = 16
) (
	input  wire              clk,
	input  wire              rst,
	input  wire tbl_cmd_t    cmd,
	input  wire [KEY_W-1:0]  wr_data,
	input  wire [KEY_W-1:0]  wr_keep,
	output logic [KEY_W-1:0] rd_data,
	output logic [KEY_W-1:0] rd_keep,
	input  wire pkt_hdr_t    in_hdr,
	input  wire              in_valid,
	output logic             in_ready,
	output match_res_t       res,
	output logic             res_valid,
	input  wire              res_ready,
	output logic             ev_hit
);

	localparam int AW = $clog2(DEPTH);

	logic [KEY_W-1:0] ent_data [DEPTH];
	logic [KEY_W-1:0] ent_keep [DEPTH];
	logic [DEPTH-1:0] ent_valid;
	logic [DEPTH-1:0] hit_vec;
	logic [AW-1:0]    hit_idx;
	logic             hit_any;
	match_res_t       mres;

	// entry data and keep words
	always_ff @(posedge clk) begin
		if (cmd.tcam_wr) begin
			ent_data[cmd.tcam_addr[AW-1:0]] <= wr_data;
			ent_keep[cmd.tcam_addr[AW-1:0]] <= wr_keep;
		end
	end

	// valid flags come up cleared
	always_ff @(posedge clk) begin
		if (rst) begin
			ent_valid <= '0;
		end else if (cmd.tcam_wr) begin
			ent_valid[cmd.tcam_addr[AW-1:0]] <= cmd.entry_valid;
		end
	end

	// read back into the staging pair
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_data <= '0;
			rd_keep <= '0;
		end else if (cmd.tcam_rd) begin
			rd_data <= ent_data[cmd.tcam_addr[AW-1:0]];
			rd_keep <= ent_keep[cmd.tcam_addr[AW-1:0]];
		end
	end

	// compare only where keep is set
	always_comb begin
		for (int i = 0; i < DEPTH; i++) begin
			hit_vec[i] = ent_valid[i] &&
				(((in_hdr.ipv4_dst ^ ent_data[i]) & ent_keep[i]) == '0);
		end
	end

	// scan down so the lowest hitting index is written last
	always_comb begin
		hit_any = 1'b0;
		hit_idx = '0;
		for (int i = DEPTH - 1; i >= 0; i--) begin
			if (hit_vec[i]) begin
				hit_any = 1'b1;
				hit_idx = AW'(i);
			end
		end
	end

	assign mres.hdr = in_hdr;
	assign mres.hit = hit_any;
	assign mres.index = 4'(hit_idx);

	pipe_stage #(
		.payload_t (match_res_t)
	) i_stage (
		.clk       (clk),
		.rst       (rst),
		.in_data   (mres),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.out_data  (res),
		.out_valid (res_valid),
		.out_ready (res_ready)
	);

	// counted when the hit result moves on
	assign ev_hit = res_valid && res_ready && res.hit;

endmodule

`default_nettype wire

//--- hw/action_table.sv
//////////////////////////////////////////////////////////////////////
// action lookup stage
// action word store with write and read back, turns the matched
// index into a drop flag and output port
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module action_table import mat_pkg::*; #(
	parameter int DEPTH = 16
) (
	input  wire              clk,
	input  wire              rst,
	input  wire tbl_cmd_t    cmd,
	input  wire [ACT_W-1:0]  wr_data,
	output logic [ACT_W-1:0] rd_data,
	input  wire match_res_t  in_res,
	input  wire              in_valid,
	output logic             in_ready,
	output act_res_t         out_res,
	output logic             out_valid,
	input  wire              out_ready
);

	localparam int AW = $clog2(DEPTH);

	logic [ACT_W-1:0] act_mem [DEPTH];
	logic [ACT_W-1:0] act_word;
	act_res_t         ares;

	// action words
	always_ff @(posedge clk) begin
		if (cmd.act_wr) begin
			act_mem[cmd.act_addr[AW-1:0]] <= wr_data;
		end
	end

	// read back
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_data <= '0;
		end else if (cmd.act_rd) begin
			rd_data <= act_mem[cmd.act_addr[AW-1:0]];
		end
	end

	assign act_word = act_mem[in_res.index[AW-1:0]];

	// a miss passes on port 0
	always_comb begin
		ares.hdr = in_res.hdr;
		ares.hit = in_res.hit;
		ares.drop = in_res.hit && act_word[ACT_DROP_BIT];
		ares.port = in_res.hit ? act_word[ACT_PORT_LSB +: PORT_W] : '0;
	end

	pipe_stage #(
		.payload_t (act_res_t)
	) i_stage (
		.clk       (clk),
		.rst       (rst),
		.in_data   (ares),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.out_data  (out_res),
		.out_valid (out_valid),
		.out_ready (out_ready)
	);

endmodule

`default_nettype wire

//--- hw/action_apply.sv
//////////////////////////////////////////////////////////////////////
// action stage
// swallows dropped headers, forwards the rest with their output port
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module action_apply import mat_pkg::*; (
	input  wire            clk,
	input  wire            rst,
	input  wire act_res_t  in_res,
	input  wire            in_valid,
	output logic           in_ready,
	output out_hdr_t       out_hdr,
	output logic           out_valid,
	input  wire            out_ready,
	output stat_ev_t       ev
);

	out_hdr_t fwd;
	logic     fwd_valid;
	logic     fwd_ready;

	assign fwd.hdr = in_res.hdr;
	assign fwd.port = in_res.port;

	// drops never enter the output slot
	assign fwd_valid = in_valid && !in_res.drop;
	// and are taken at once
	assign in_ready = fwd_ready || (in_valid && in_res.drop);

	pipe_stage #(
		.payload_t (out_hdr_t)
	) i_stage (
		.clk       (clk),
		.rst       (rst),
		.in_data   (fwd),
		.in_valid  (fwd_valid),
		.in_ready  (fwd_ready),
		.out_data  (out_hdr),
		.out_valid (out_valid),
		.out_ready (out_ready)
	);

	// input and hit events come from elsewhere
	assign ev.in_beat = 1'b0;
	assign ev.hit = 1'b0;
	assign ev.out_beat = out_valid && out_ready;
	assign ev.drop = in_valid && in_ready && in_res.drop;

endmodule

`default_nettype wire

//--- hw/stat_counters.sv
//////////////////////////////////////////////////////////////////////
// traffic counters
// input, hit, output and drop beats, wrapping, with a common clear
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module stat_counters import mat_pkg::*; (
	input  wire               clk,
	input  wire               rst,
	input  wire stat_ev_t     ev,
	input  wire               clear,
	output logic [REG_DW-1:0] cnt_in,
	output logic [REG_DW-1:0] cnt_hit,
	output logic [REG_DW-1:0] cnt_out,
	output logic [REG_DW-1:0] cnt_drop
);

	// clear beats any event in the same cycle
	always_ff @(posedge clk) begin
		if (rst || clear) begin
			cnt_in <= '0;
			cnt_hit <= '0;
			cnt_out <= '0;
			cnt_drop <= '0;
		end else begin
			cnt_in <= cnt_in + REG_DW'(ev.in_beat);
			cnt_hit <= cnt_hit + REG_DW'(ev.hit);
			cnt_out <= cnt_out + REG_DW'(ev.out_beat);
			cnt_drop <= cnt_drop + REG_DW'(ev.drop);
		end
	end

endmodule

`default_nettype wire

//--- hw/csr_regs.sv
//////////////////////////////////////////////////////////////////////
// register block
// address decode, write staging, one-cycle table command and counter
// clear, registered read mux, enable/acknowledge handshake
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module csr_regs import mat_pkg::*; (
	input  wire               clk,
	input  wire               rst,
	input  wire               reg_wr_en,
	input  wire [REG_AW-1:0]  reg_wr_addr,
	input  wire [REG_DW-1:0]  reg_wr_data,
	output logic              reg_wr_ack,
	input  wire               reg_rd_en,
	input  wire [REG_AW-1:0]  reg_rd_addr,
	output logic [REG_DW-1:0] reg_rd_data,
	output logic              reg_rd_ack,
	output tbl_cmd_t          cmd,
	output logic [KEY_W-1:0]  tcam_wr_data,
	output logic [KEY_W-1:0]  tcam_wr_keep,
	output logic [ACT_W-1:0]  act_wr_data,
	input  wire [KEY_W-1:0]   tcam_rd_data,
	input  wire [KEY_W-1:0]   tcam_rd_keep,
	input  wire [ACT_W-1:0]   act_rd_data,
	input  wire [REG_DW-1:0]  cnt_in,
	input  wire [REG_DW-1:0]  cnt_hit,
	input  wire [REG_DW-1:0]  cnt_out,
	input  wire [REG_DW-1:0]  cnt_drop,
	output logic              clear
);

	tbl_cmd_t          cmd_dec;
	logic [REG_DW-1:0] rd_mux;

	// split the command word
	always_comb begin
		cmd_dec.tcam_wr = reg_wr_data[CMD_TCAM_WR];
		cmd_dec.tcam_rd = reg_wr_data[CMD_TCAM_RD];
		cmd_dec.act_wr = reg_wr_data[CMD_ACT_WR];
		cmd_dec.act_rd = reg_wr_data[CMD_ACT_RD];
		cmd_dec.tcam_addr = reg_wr_data[CMD_TCAM_ADDR_LSB +: 4];
		cmd_dec.act_addr = reg_wr_data[CMD_ACT_ADDR_LSB +: 4];
		cmd_dec.entry_valid = reg_wr_data[CMD_TCAM_VALID];
	end

	// command and clear last one cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			reg_wr_ack <= 1'b0;
			cmd <= '0;
			clear <= 1'b0;
			tcam_wr_data <= '0;
			tcam_wr_keep <= '0;
			act_wr_data <= '0;
		end else begin
			reg_wr_ack <= reg_wr_en;
			cmd <= '0;
			clear <= 1'b0;
			if (reg_wr_en) begin
				case (reg_wr_addr)
					REG_CMD:       cmd <= cmd_dec;
					REG_TCAM_DATA: tcam_wr_data <= reg_wr_data;
					REG_TCAM_KEEP: tcam_wr_keep <= reg_wr_data;
					REG_ACT_DATA:  act_wr_data <= reg_wr_data;
					REG_CLR:       clear <= reg_wr_data[0];
					// anything else is acked and dropped
					default: ;
				endcase
			end
		end
	end

	// unmapped reads give zero
	always_comb begin
		case (reg_rd_addr)
			REG_TCAM_DATA:    rd_mux = tcam_wr_data;
			REG_TCAM_KEEP:    rd_mux = tcam_wr_keep;
			REG_ACT_DATA:     rd_mux = act_wr_data;
			REG_TCAM_RD_DATA: rd_mux = tcam_rd_data;
			REG_TCAM_RD_KEEP: rd_mux = tcam_rd_keep;
			REG_ACT_RD_DATA:  rd_mux = act_rd_data;
			REG_CNT_IN:       rd_mux = cnt_in;
			REG_CNT_HIT:      rd_mux = cnt_hit;
			REG_CNT_OUT:      rd_mux = cnt_out;
			REG_CNT_DROP:     rd_mux = cnt_drop;
			default:          rd_mux = '0;
		endcase
	end

	// read data and ack come one cycle after the enable
	always_ff @(posedge clk) begin
		if (rst) begin
			reg_rd_ack <= 1'b0;
			reg_rd_data <= '0;
		end else begin
			reg_rd_ack <= reg_rd_en;
			if (reg_rd_en) begin
				reg_rd_data <= rd_mux;
			end
		end
	end

	// master waits for the ack before the next request
	assert property (@(posedge clk) disable iff (rst)
		reg_wr_ack |=> !reg_wr_ack);

endmodule

`default_nettype wire

//--- hw/mat_core.sv
//////////////////////////////////////////////////////////////////////
// match-action core top level
// register block and counters beside a three-stage header pipeline
// of ternary match, action lookup and action apply
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mat_core import mat_pkg::*; #(
	parameter int DEPTH = TBL_DEPTH
) (
	input  wire               clk,
	input  wire               rst,
	input  wire pkt_hdr_t     in_hdr,
	input  wire               in_valid,
	output logic              in_ready,
	output out_hdr_t          out_hdr,
	output logic              out_valid,
	input  wire               out_ready,
	input  wire               reg_wr_en,
	input  wire [REG_AW-1:0]  reg_wr_addr,
	input  wire [REG_DW-1:0]  reg_wr_data,
	output logic              reg_wr_ack,
	input  wire               reg_rd_en,
	input  wire [REG_AW-1:0]  reg_rd_addr,
	output logic [REG_DW-1:0] reg_rd_data,
	output logic              reg_rd_ack
);

	tbl_cmd_t          cmd;
	logic [KEY_W-1:0]  tcam_wr_data;
	logic [KEY_W-1:0]  tcam_wr_keep;
	logic [ACT_W-1:0]  act_wr_data;
	logic [KEY_W-1:0]  tcam_rd_data;
	logic [KEY_W-1:0]  tcam_rd_keep;
	logic [ACT_W-1:0]  act_rd_data;
	logic [REG_DW-1:0] cnt_in;
	logic [REG_DW-1:0] cnt_hit;
	logic [REG_DW-1:0] cnt_out;
	logic [REG_DW-1:0] cnt_drop;
	logic              clear;
	match_res_t        mres;
	logic              mres_valid;
	logic              mres_ready;
	act_res_t          ares;
	logic              ares_valid;
	logic              ares_ready;
	logic              ev_hit;
	stat_ev_t          ev_apply;
	stat_ev_t          ev;

	// input beat comes from the input handshake
	assign ev.in_beat = in_valid && in_ready;
	assign ev.hit = ev_hit;
	assign ev.out_beat = ev_apply.out_beat;
	assign ev.drop = ev_apply.drop;

	csr_regs i_csr_regs (
		.clk          (clk),
		.rst          (rst),
		.reg_wr_en    (reg_wr_en),
		.reg_wr_addr  (reg_wr_addr),
		.reg_wr_data  (reg_wr_data),
		.reg_wr_ack   (reg_wr_ack),
		.reg_rd_en    (reg_rd_en),
		.reg_rd_addr  (reg_rd_addr),
		.reg_rd_data  (reg_rd_data),
		.reg_rd_ack   (reg_rd_ack),
		.cmd          (cmd),
		.tcam_wr_data (tcam_wr_data),
		.tcam_wr_keep (tcam_wr_keep),
		.act_wr_data  (act_wr_data),
		.tcam_rd_data (tcam_rd_data),
		.tcam_rd_keep (tcam_rd_keep),
		.act_rd_data  (act_rd_data),
		.cnt_in       (cnt_in),
		.cnt_hit      (cnt_hit),
		.cnt_out      (cnt_out),
		.cnt_drop     (cnt_drop),
		.clear        (clear)
	);

	stat_counters i_stat_counters (
		.clk      (clk),
		.rst      (rst),
		.ev       (ev),
		.clear    (clear),
		.cnt_in   (cnt_in),
		.cnt_hit  (cnt_hit),
		.cnt_out  (cnt_out),
		.cnt_drop (cnt_drop)
	);

	// stage one
	tcam_match #(
		.DEPTH (DEPTH)
	) i_tcam_match (
		.clk       (clk),
		.rst       (rst),
		.cmd       (cmd),
		.wr_data   (tcam_wr_data),
		.wr_keep   (tcam_wr_keep),
		.rd_data   (tcam_rd_data),
		.rd_keep   (tcam_rd_keep),
		.in_hdr    (in_hdr),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.res       (mres),
		.res_valid (mres_valid),
		.res_ready (mres_ready),
		.ev_hit    (ev_hit)
	);

	// stage two
	action_table #(
		.DEPTH (DEPTH)
	) i_action_table (
		.clk       (clk),
		.rst       (rst),
		.cmd       (cmd),
		.wr_data   (act_wr_data),
		.rd_data   (act_rd_data),
		.in_res    (mres),
		.in_valid  (mres_valid),
		.in_ready  (mres_ready),
		.out_res   (ares),
		.out_valid (ares_valid),
		.out_ready (ares_ready)
	);

	// stage three
	action_apply i_action_apply (
		.clk       (clk),
		.rst       (rst),
		.in_res    (ares),
		.in_valid  (ares_valid),
		.in_ready  (ares_ready),
		.out_hdr   (out_hdr),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.ev        (ev_apply)
	);

endmodule

`default_nettype wire

//--- tests/tb_mat_core.sv
//////////////////////////////////////////////////////////////////////
// match-action core testbench
// random table contents and headers from a fixed seed, checked
// against a ternary lookup model, with random back-pressure
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_mat_core import mat_pkg::*; ();

	localparam int HALF = 20;
	localparam int SETTLE = 1;
	localparam int TIMEOUT = 2000;
	localparam logic [31:0] SEED = 32'hc47e7736;

	logic              clk;
	logic              rst;
	pkt_hdr_t          in_hdr;
	logic              in_valid;
	logic              in_ready;
	out_hdr_t          out_hdr;
	logic              out_valid;
	logic              out_ready;
	logic              reg_wr_en;
	logic [REG_AW-1:0] reg_wr_addr;
	logic [REG_DW-1:0] reg_wr_data;
	logic              reg_wr_ack;
	logic              reg_rd_en;
	logic [REG_AW-1:0] reg_rd_addr;
	logic [REG_DW-1:0] reg_rd_data;
	logic              reg_rd_ack;

	// reference copy of the tables
	logic [31:0] m_data [TBL_DEPTH];
	logic [31:0] m_keep [TBL_DEPTH];
	logic        m_valid [TBL_DEPTH];
	logic [31:0] m_act [TBL_DEPTH];
	// forwarded headers in input order
	out_hdr_t    exp_q [$];
	int          n_in;
	int          n_hit;
	int          n_drop;
	int          seq;
	int          errors;
	int          test_errors;
	int          tests_run;
	int          tests_failed;

	mat_core #(
		.DEPTH (TBL_DEPTH)
	) i_mat_core (
		.clk         (clk),
		.rst         (rst),
		.in_hdr      (in_hdr),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.out_hdr     (out_hdr),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.reg_wr_en   (reg_wr_en),
		.reg_wr_addr (reg_wr_addr),
		.reg_wr_data (reg_wr_data),
		.reg_wr_ack  (reg_wr_ack),
		.reg_rd_en   (reg_rd_en),
		.reg_rd_addr (reg_rd_addr),
		.reg_rd_data (reg_rd_data),
		.reg_rd_ack  (reg_rd_ack)
	);

	always #HALF clk = ~clk;

	task automatic count_error();
		errors++;
		test_errors++;
	endtask

	task automatic check(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
			count_error();
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors != 0) begin
			tests_failed++;
		end
		$display("test %s: %s", name, (test_errors == 0) ? "ok" : "failed");
		test_errors = 0;
	endtask

	task automatic reg_write(input logic [REG_AW-1:0] addr, input logic [REG_DW-1:0] data);
		int n;
		@(negedge clk);
		reg_wr_en = 1'b1;
		reg_wr_addr = addr;
		reg_wr_data = data;
		@(negedge clk);
		reg_wr_en = 1'b0;
		n = 0;
		while (!reg_wr_ack && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (!reg_wr_ack) begin
			$display("register write to 0x%h was never acknowledged", addr);
			count_error();
		end
	endtask

	task automatic reg_read(input logic [REG_AW-1:0] addr, output logic [REG_DW-1:0] data);
		int n;
		@(negedge clk);
		reg_rd_en = 1'b1;
		reg_rd_addr = addr;
		@(negedge clk);
		reg_rd_en = 1'b0;
		n = 0;
		while (!reg_rd_ack && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		data = reg_rd_data;
		if (!reg_rd_ack) begin
			$display("register read from 0x%h was never acknowledged", addr);
			count_error();
		end
	endtask

	// returns {hit, drop, port} of the first valid entry agreeing under its mask
	function automatic logic [5:0] lookup(input logic [31:0] key);
		logic [5:0] r;
		logic       found;
		r = '0;
		found = 1'b0;
		for (int i = 0; i < TBL_DEPTH; i++) begin
			if (!found && m_valid[i] &&
				((key & m_keep[i]) == (m_data[i] & m_keep[i]))) begin
				found = 1'b1;
				r = {1'b1, m_act[i][ACT_DROP_BIT], m_act[i][3:0]};
			end
		end
		return r;
	endfunction

	// mostly keys aimed at one entry and some fully random
	function automatic logic [31:0] make_key();
		int e;
		e = $urandom % TBL_DEPTH;
		if ($urandom % 4 == 0) begin
			return $urandom;
		end
		return (m_data[e] & m_keep[e]) | ($urandom & ~m_keep[e]);
	endfunction

	task automatic run_traffic(input string name, input int count, input int gap_pct,
		input int stall_pct);
		int         sent;
		int         idle;
		logic       took;
		logic [5:0] r;
		out_hdr_t   e;
		sent = 0;
		idle = 0;
		took = 1'b0;
		while ((sent < count || exp_q.size() != 0) && idle < TIMEOUT) begin
			@(negedge clk);
			idle++;
			if (took) begin
				in_valid = 1'b0;
			end
			// hold an unaccepted header or maybe start a new one
			if (!in_valid && sent < count && ($urandom % 100) >= gap_pct) begin
				in_hdr.ipv4_dst = make_key();
				in_hdr.flow_id = seq[7:0];
				seq++;
				in_valid = 1'b1;
			end
			out_ready = ($urandom % 100) >= stall_pct;
			// handshakes for the next edge are fixed once inputs settle
			#SETTLE;
			took = in_valid && in_ready;
			if (took) begin
				r = lookup(in_hdr.ipv4_dst);
				n_in++;
				n_hit += int'(r[5]);
				n_drop += int'(r[4]);
				if (!r[4]) begin
					e.hdr = in_hdr;
					e.port = r[3:0];
					exp_q.push_back(e);
				end
				sent++;
				idle = 0;
			end
			if (out_valid && out_ready) begin
				idle = 0;
				if (exp_q.size() == 0) begin
					$display("%s: output flow %0d appeared with nothing expected", name,
						out_hdr.hdr.flow_id);
					count_error();
				end else begin
					e = exp_q.pop_front();
					check({name, " header"}, 64'(e), 64'(out_hdr));
				end
			end
		end
		if (idle >= TIMEOUT) begin
			$display("%s: pipeline stalled with %0d headers outstanding", name,
				exp_q.size());
			count_error();
		end
		@(negedge clk);
		in_valid = 1'b0;
		out_ready = 1'b1;
	endtask

	initial begin
		logic [31:0] v;
		logic [31:0] cmd_word;
		int          n;
		clk = 1'b0;
		rst = 1'b1;
		in_hdr = '0;
		in_valid = 1'b0;
		out_ready = 1'b0;
		reg_wr_en = 1'b0;
		reg_wr_addr = '0;
		reg_wr_data = '0;
		reg_rd_en = 1'b0;
		reg_rd_addr = '0;
		void'($urandom(SEED));
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// fill both tables with overlapping prefixes under 10.x
		for (int i = 0; i < TBL_DEPTH; i++) begin
			case ($urandom % 5)
				0: m_keep[i] = 32'hff00_0000;
				1: m_keep[i] = 32'hffff_0000;
				2: m_keep[i] = 32'hffff_ff00;
				3: m_keep[i] = 32'hffff_ffff;
				default: m_keep[i] = $urandom;
			endcase
			m_data[i] = {8'h0a, 6'h00, 2'($urandom), 16'($urandom)};
			m_valid[i] = ($urandom % 8) != 0;
			m_act[i] = $urandom;
			reg_write(REG_TCAM_DATA, m_data[i]);
			reg_write(REG_TCAM_KEEP, m_keep[i]);
			reg_write(REG_ACT_DATA, m_act[i]);
			cmd_word = (32'h1 << CMD_TCAM_WR) | (32'h1 << CMD_ACT_WR) |
				(32'(m_valid[i]) << CMD_TCAM_VALID) |
				(32'(i) << CMD_TCAM_ADDR_LSB) | (32'(i) << CMD_ACT_ADDR_LSB);
			reg_write(REG_CMD, cmd_word);
		end
		// one command reads both tables back
		for (int i = 0; i < TBL_DEPTH; i++) begin
			cmd_word = (32'h1 << CMD_TCAM_RD) | (32'h1 << CMD_ACT_RD) |
				(32'(i) << CMD_TCAM_ADDR_LSB) | (32'(i) << CMD_ACT_ADDR_LSB);
			reg_write(REG_CMD, cmd_word);
			reg_read(REG_TCAM_RD_DATA, v);
			check($sformatf("readback tcam data %0d", i), 64'(m_data[i]), 64'(v));
			reg_read(REG_TCAM_RD_KEEP, v);
			check($sformatf("readback tcam keep %0d", i), 64'(m_keep[i]), 64'(v));
			reg_read(REG_ACT_RD_DATA, v);
			check($sformatf("readback action %0d", i), 64'(m_act[i]), 64'(v));
		end
		finish_test("readback");

		// full rate, priority and drops
		run_traffic("match_drop", 200, 0, 0);
		finish_test("match_drop");

		// input gaps and output stalls
		run_traffic("backpressure", 300, 30, 40);
		finish_test("backpressure");

		// a dropped header can still be in flight
		n = 0;
		reg_read(REG_CNT_DROP, v);
		while (v != 32'(n_drop) && n < TIMEOUT) begin
			reg_read(REG_CNT_DROP, v);
			n++;
		end
		check("counters drop", 64'(n_drop), 64'(v));
		reg_read(REG_CNT_IN, v);
		check("counters in", 64'(n_in), 64'(v));
		reg_read(REG_CNT_HIT, v);
		check("counters hit", 64'(n_hit), 64'(v));
		reg_read(REG_CNT_OUT, v);
		check("counters out", 64'(n_in - n_drop), 64'(v));
		finish_test("counters");

		reg_write(REG_CLR, 32'h1);
		reg_read(REG_CNT_IN, v);
		check("clear in", 64'h0, 64'(v));
		reg_read(REG_CNT_HIT, v);
		check("clear hit", 64'h0, 64'(v));
		reg_read(REG_CNT_OUT, v);
		check("clear out", 64'h0, 64'(v));
		reg_read(REG_CNT_DROP, v);
		check("clear drop", 64'h0, 64'(v));
		finish_test("clear");

		$display("tests run %0d, tests with errors %0d, errors %0d", tests_run, tests_failed,
			errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
hw/mat_pkg.sv
hw/pipe_stage.sv
hw/tcam_match.sv
hw/action_table.sv
hw/action_apply.sv
hw/stat_counters.sv
hw/csr_regs.sv
hw/mat_core.sv
tests/tb_mat_core.sv

//--- Makefile
SIM      = verilator
FLAGS    = --timing --assert
TOP      = tb_mat_core
FILELIST = files.f
OBJ      = obj_dir
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(SIM) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
